// ==== verilog.f ====
+incdir+source
source/mul_pkg.sv
source/booth_r4_encoder.sv
source/compressor_42.sv
source/compressor_52.sv
source/wallace_stage_first.sv
source/wallace_stage_42.sv
source/mul_ctrl.sv
source/wallace_mul.sv
test/tb_wallace_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the wallace multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_wallace_mul \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_wallace_mul > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict comes from the log
if grep -q "^Test passed$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== test/tb_wallace_mul.sv ====
`include "mul_macros.svh"

module tb_wallace_mul;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int XW = `MUL_XLEN;
  localparam int PW = `MUL_PROD_W;

  logic              clk;
  logic              rst;
  mul_pkg::mul_req_t req_i;
  logic              valid_i;
  logic              ready_o;
  logic [PW-1:0]     product_o;

  int     errors;
  integer seed;

  wallace_mul i_wallace_mul (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_i),
    .valid_i   (valid_i),
    .ready_o   (ready_o),
    .product_o (product_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // operands widened by their flags, product kept modulo 2^64
  function automatic logic [PW-1:0] ref_product(input logic [XW-1:0] a,
                                                input logic [XW-1:0] b,
                                                input logic          sa,
                                                input logic          sb);
    logic [PW-1:0] ea;
    logic [PW-1:0] eb;
    ea = {{(PW - XW){sa & a[XW-1]}}, a};
    eb = {{(PW - XW){sb & b[XW-1]}}, b};
    return ea * eb;
  endfunction

  // one full multiplication, checked for value, latency and pulse width
  task automatic run_op(input string         name,
                        input logic [XW-1:0] a,
                        input logic [XW-1:0] b,
                        input logic          sa,
                        input logic          sb);
    mul_pkg::mul_req_t req;
    logic [PW-1:0]     expected;
    int                edges;
    bit                seen;
    req.rs1_data   = a;
    req.rs2_data   = b;
    req.rs1_signed = sa;
    req.rs2_signed = sb;
    expected = ref_product(a, b, sa, sb);
    @(posedge clk);
    req_i   <= req;
    valid_i <= 1'b1;
    edges = 0;
    seen  = 1'b0;
    // first edge counted is the one where idle sees valid
    while (!seen && edges < 10) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (ready_o) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("%s: ready_o did not arrive within 10 cycles", name);
      errors++;
    end else begin
      if (edges != 5) begin
        $display("FAIL %s latency expected 5 actual %0d", name, edges);
        errors++;
      end
      if (product_o !== expected) begin
        $display("FAIL %s product expected %h actual %h", name, expected, product_o);
        errors++;
      end
    end
    @(posedge clk);
    valid_i <= 1'b0;
    @(negedge clk);
    if (seen && ready_o) begin
      $display("%s: ready_o stayed high for more than one cycle", name);
      errors++;
    end
  endtask

  task automatic test_reset;
    int cyc;
    for (cyc = 0; cyc < 5; cyc++) begin
      @(negedge clk);
      if (ready_o !== 1'b0) begin
        $display("FAIL reset ready_o expected 0 actual %b", ready_o);
        errors++;
      end
      if (product_o !== '0) begin
        $display("FAIL reset product_o expected %h actual %h", {PW{1'b0}}, product_o);
        errors++;
      end
    end
  endtask

  task automatic test_unsigned_corners;
    run_op("unsigned zero times x", 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0);
    run_op("unsigned one times x", 32'h0000_0001, 32'hdead_beef, 1'b0, 1'b0);
    run_op("unsigned max times max", 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0);
    run_op("unsigned msb squared", 32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0);
  endtask

  // every case under all four flag combinations
  task automatic test_signed_mixed;
    logic [XW-1:0] op_a [4];
    logic [XW-1:0] op_b [4];
    logic [1:0]    fs;
    int            idx;
    int            f;
    op_a[0] = 32'hffff_ffff;
    op_b[0] = 32'hffff_ffff;
    op_a[1] = 32'h8000_0000;
    op_b[1] = 32'h8000_0000;
    op_a[2] = 32'h8000_0000;
    op_b[2] = 32'h7fff_ffff;
    // -10 against the unsigned maximum
    op_a[3] = 32'hffff_fff6;
    op_b[3] = 32'hffff_ffff;
    for (idx = 0; idx < 4; idx++) begin
      for (f = 0; f < 4; f++) begin
        fs = f[1:0];
        run_op($sformatf("signed case %0d flags %0d", idx, f),
               op_a[idx], op_b[idx], fs[1], fs[0]);
      end
    end
  endtask

  task automatic test_random;
    logic [XW-1:0] a;
    logic [XW-1:0] b;
    logic [31:0]   r;
    int            i;
    for (i = 0; i < 40; i++) begin
      a = $random(seed);
      b = $random(seed);
      r = $random(seed);
      run_op($sformatf("random %0d", i), a, b, r[0], r[1]);
    end
  endtask

  task automatic test_abort;
    mul_pkg::mul_req_t req;
    bit                seen;
    int                cyc;
    req.rs1_data   = 32'h0000_7b2d;
    req.rs2_data   = 32'hfff0_0313;
    req.rs1_signed = 1'b0;
    req.rs2_signed = 1'b1;
    @(posedge clk);
    req_i   <= req;
    valid_i <= 1'b1;
    // valid seen for two edges only
    repeat (2) @(posedge clk);
    valid_i <= 1'b0;
    seen = 1'b0;
    for (cyc = 0; cyc < 8; cyc++) begin
      @(negedge clk);
      if (ready_o) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      $display("abort: ready_o pulsed after valid_i was dropped");
      errors++;
    end
    if (product_o !== '0) begin
      $display("FAIL abort product_o expected %h actual %h", {PW{1'b0}}, product_o);
      errors++;
    end
    run_op("abort follow-up", 32'h0000_7b2d, 32'hfff0_0313, 1'b0, 1'b1);
  endtask

  initial begin
    rst     = 1'b1;
    valid_i = 1'b0;
    req_i   = '0;
    errors  = 0;
    seed    = 32'h8bef_e9f8;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_reset();
    test_unsigned_corners();
    test_signed_mixed();
    test_random();
    test_abort();

    repeat (2) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/wallace_mul.sv ====
`include "mul_macros.svh"

module wallace_mul (
  input  logic                    clk,
  input  logic                    rst,
  input  mul_pkg::mul_req_t       req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output logic [`MUL_PROD_W-1:0]  product_o
);

  mul_pkg::pp_first_t                      pp;
  mul_pkg::pp_row_t [`MUL_L1_ROWS-1:0]     rows_l1;
  mul_pkg::pp_row_t [`MUL_L1_ROWS/2-1:0]   rows_l2;
  mul_pkg::pp_row_t [1:0]                  rows_l3;

  booth_r4_encoder u_booth (
    .req_i (req_i),
    .pp_o  (pp)
  );

  // 17 -> 8
  wallace_stage_first u_stage_first (
    .clk    (clk),
    .rst    (rst),
    .pp_i   (pp),
    .rows_o (rows_l1)
  );

  wallace_stage_42 #(
    .ROWS_IN (`MUL_L1_ROWS)
  ) u_stage_8to4 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (rows_l1),
    .rows_o (rows_l2)
  );

  wallace_stage_42 #(
    .ROWS_IN (`MUL_L1_ROWS / 2)
  ) u_stage_4to2 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (rows_l2),
    .rows_o (rows_l3)
  );

  // final add and sequencing
  mul_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .valid_i   (valid_i),
    .rows_i    (rows_l3),
    .ready_o   (ready_o),
    .product_o (product_o)
  );

endmodule

// ==== source/mul_ctrl.sv ====
module mul_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        valid_i,
  input  mul_pkg::pp_row_t [1:0]      rows_i,
  output logic                        ready_o,
  output mul_pkg::pp_row_t            product_o
);

  mul_pkg::mul_state_e state_q;
  mul_pkg::pp_row_t    final_sum;

  // carry row arrives already shifted from the last stage
  assign final_sum = rows_i[0] + rows_i[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= mul_pkg::MUL_IDLE;
      ready_o   <= 1'b0;
      product_o <= '0;
    end else begin
      // pulse only, dropped unless set below
      ready_o <= 1'b0;
      if (!valid_i) begin
        // abandon whatever was in flight
        state_q   <= mul_pkg::MUL_IDLE;
        product_o <= '0;
      end else begin
        case (state_q)
          mul_pkg::MUL_IDLE:  state_q <= mul_pkg::MUL_STEP1;
          mul_pkg::MUL_STEP1: state_q <= mul_pkg::MUL_STEP2;
          mul_pkg::MUL_STEP2: state_q <= mul_pkg::MUL_STEP3;
          mul_pkg::MUL_STEP3: state_q <= mul_pkg::MUL_STEP4;
          mul_pkg::MUL_STEP4: begin
            state_q   <= mul_pkg::MUL_IDLE;
            product_o <= final_sum;
            ready_o   <= 1'b1;
          end
          default: state_q <= mul_pkg::MUL_IDLE;
        endcase
      end
    end
  end

  a_ready_single : assert property (
    @(posedge clk) disable iff (rst) ready_o |=> !ready_o
  );

  // ready only follows a completed step 4
  a_ready_after_step4 : assert property (
    @(posedge clk) disable iff (rst)
    ready_o |-> $past(state_q == mul_pkg::MUL_STEP4 && valid_i)
  );

  a_abort_clears : assert property (
    @(posedge clk) disable iff (rst) !valid_i |=> (product_o == '0)
  );

endmodule

// ==== source/wallace_stage_42.sv ====
module wallace_stage_42 #(
  parameter int ROWS_IN = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  mul_pkg::pp_row_t [ROWS_IN-1:0]      rows_i,
  output mul_pkg::pp_row_t [ROWS_IN/2-1:0]    rows_o
);

  localparam int W      = $bits(mul_pkg::pp_row_t);
  localparam int GROUPS = ROWS_IN / 4;

  mul_pkg::pp_row_t [ROWS_IN-1:0] rows_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rows_q <= '0;
    end else begin
      rows_q <= rows_i;
    end
  end

  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    logic [W:0]       chain;
    mul_pkg::pp_row_t sum_row;
    mul_pkg::pp_row_t carry_row;

    assign chain[0] = 1'b0;

    for (genvar b = 0; b < W; b++) begin : g_bit
      compressor_42 u_c42 (
        .x0_i    (rows_q[4*g][b]),
        .x1_i    (rows_q[4*g + 1][b]),
        .x2_i    (rows_q[4*g + 2][b]),
        .x3_i    (rows_q[4*g + 3][b]),
        .ci_i    (chain[b]),
        .sum_o   (sum_row[b]),
        .co_o    (chain[b+1]),
        .carry_o (carry_row[b])
      );
    end

    // sums in the lower half, aligned carries in the upper half
    assign rows_o[g]          = sum_row;
    assign rows_o[GROUPS + g] = {carry_row[W-2:0], 1'b0};
  end

  // groups of four must cover every input row
  a_rows_multiple_of_4 : assert property (
    @(posedge clk) disable iff (rst) (ROWS_IN % 4) == 0
  );

endmodule

// ==== source/wallace_stage_first.sv ====
`include "mul_macros.svh"

module wallace_stage_first (
  input  logic                                  clk,
  input  logic                                  rst,
  input  mul_pkg::pp_first_t                    pp_i,
  output mul_pkg::pp_row_t [`MUL_L1_ROWS-1:0]   rows_o
);

  localparam int W       = `MUL_PROD_W;
  localparam int N42     = (`MUL_PP_ROWS - 5) / 4;

  mul_pkg::pp_first_t pp_q;

  // pipeline register in front of the first level
  always_ff @(posedge clk) begin
    if (rst) begin
      pp_q <= '0;
    end else begin
      pp_q <= pp_i;
    end
  end

  // rows 0..4 through one 5-2 row
  logic [W:0]       c52_chain0;
  logic [W:0]       c52_chain1;
  mul_pkg::pp_row_t sum52;
  mul_pkg::pp_row_t carry52;

  assign c52_chain0[0] = 1'b0;
  assign c52_chain1[0] = 1'b0;

  for (genvar b = 0; b < W; b++) begin : g_c52
    compressor_52 u_c52 (
      .x0_i    (pp_q[0][b]),
      .x1_i    (pp_q[1][b]),
      .x2_i    (pp_q[2][b]),
      .x3_i    (pp_q[3][b]),
      .x4_i    (pp_q[4][b]),
      .cin0_i  (c52_chain0[b]),
      .cin1_i  (c52_chain1[b]),
      .cout0_o (c52_chain0[b+1]),
      .cout1_o (c52_chain1[b+1]),
      .sum_o   (sum52[b]),
      .carry_o (carry52[b])
    );
  end

  assign rows_o[0] = sum52;
  assign rows_o[4] = {carry52[W-2:0], 1'b0};

  // rows 5..16 in groups of four
  for (genvar g = 0; g < N42; g++) begin : g_row42
    logic [W:0]       chain;
    mul_pkg::pp_row_t sum_row;
    mul_pkg::pp_row_t carry_row;

    assign chain[0] = 1'b0;

    for (genvar b = 0; b < W; b++) begin : g_bit
      compressor_42 u_c42 (
        .x0_i    (pp_q[5 + 4*g][b]),
        .x1_i    (pp_q[6 + 4*g][b]),
        .x2_i    (pp_q[7 + 4*g][b]),
        .x3_i    (pp_q[8 + 4*g][b]),
        .ci_i    (chain[b]),
        .sum_o   (sum_row[b]),
        .co_o    (chain[b+1]),
        .carry_o (carry_row[b])
      );
    end

    // top lateral carry is beyond the product width
    assign rows_o[1 + g] = sum_row;
    assign rows_o[5 + g] = {carry_row[W-2:0], 1'b0};
  end

endmodule

// ==== source/compressor_52.sv ====
module compressor_52 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic x4_i,
  input  logic cin0_i,
  input  logic cin1_i,
  output logic cout0_o,
  output logic cout1_o,
  output logic sum_o,
  output logic carry_o
);

  logic s1;
  logic s2;

  // three direct inputs
  assign s1      = x0_i ^ x1_i ^ x2_i;
  assign cout0_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  // remaining two inputs with the first partial sum
  assign s2      = s1 ^ x3_i ^ x4_i;
  assign cout1_o = (s1 & x3_i) | (s1 & x4_i) | (x3_i & x4_i);

  // lateral carries from the bit below
  assign sum_o   = s2 ^ cin0_i ^ cin1_i;
  assign carry_o = (s2 & cin0_i) | (s2 & cin1_i) | (cin0_i & cin1_i);

endmodule

// ==== source/compressor_42.sv ====
module compressor_42 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic ci_i,
  output logic sum_o,
  output logic co_o,
  output logic carry_o
);

  logic s1;

  // first full adder, its carry goes sideways to the next bit
  assign s1   = x0_i ^ x1_i ^ x2_i;
  assign co_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  // second full adder folds in x3 and the lateral carry
  assign sum_o   = s1 ^ x3_i ^ ci_i;
  assign carry_o = (s1 & x3_i) | (s1 & ci_i) | (x3_i & ci_i);

endmodule

// ==== source/booth_r4_encoder.sv ====
`include "mul_macros.svh"

module booth_r4_encoder (
  input  mul_pkg::mul_req_t  req_i,
  output mul_pkg::pp_first_t pp_o
);

  // two extra bits so unsigned operands look like positive signed ones
  localparam int EXT_W = `MUL_XLEN + 2;
  localparam int PW    = `MUL_PROD_W;

  logic [EXT_W-1:0] a_ext;
  logic [EXT_W-1:0] b_ext;
  // multiplier with the implicit zero below bit 0
  logic [EXT_W:0]   b_win;
  logic [PW-1:0]    mcand;
  logic [PW-1:0]    mcand_x2;

  always_comb begin
    a_ext = {{2{req_i.rs1_signed & req_i.rs1_data[`MUL_XLEN-1]}}, req_i.rs1_data};
    b_ext = {{2{req_i.rs2_signed & req_i.rs2_data[`MUL_XLEN-1]}}, req_i.rs2_data};
    b_win = {b_ext, 1'b0};
  end

  // multiplicand sign-extended to full row width
  assign mcand    = {{(PW - EXT_W){a_ext[EXT_W-1]}}, a_ext};
  assign mcand_x2 = {mcand[PW-2:0], 1'b0};

  always_comb begin
    logic [2:0]    grp;
    logic [PW-1:0] sel;
    for (int i = 0; i < `MUL_PP_ROWS; i++) begin
      // overlapping triplet b[2i+1], b[2i], b[2i-1]
      grp = b_win[2*i+2 -: 3];
      case (grp)
        3'b001,
        3'b010: sel = mcand;
        3'b011: sel = mcand_x2;
        3'b100: sel = ~mcand_x2 + 1'b1;
        3'b101,
        3'b110: sel = ~mcand + 1'b1;
        default: sel = '0;
      endcase
      // weight of row i is 4^i
      pp_o[i] = sel << (2 * i);
    end
  end

endmodule

// ==== source/mul_pkg.sv ====
`include "mul_macros.svh"

package mul_pkg;

  // operands with their signedness flags
  typedef struct packed {
    logic [`MUL_XLEN-1:0] rs1_data;
    logic [`MUL_XLEN-1:0] rs2_data;
    logic                 rs1_signed;
    logic                 rs2_signed;
  } mul_req_t;

  // one row of the reduction tree
  typedef logic [`MUL_PROD_W-1:0] pp_row_t;

  // all booth partial products, row 0 at the bottom
  typedef pp_row_t [`MUL_PP_ROWS-1:0] pp_first_t;

  // sequencing states of the controller
  typedef enum logic [2:0] {
    MUL_IDLE,
    MUL_STEP1,
    MUL_STEP2,
    MUL_STEP3,
    MUL_STEP4
  } mul_state_e;

endpackage

// ==== source/mul_macros.svh ====
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand width of rs1 and rs2
`define MUL_XLEN 32

// full product width, also the width of every tree row
`define MUL_PROD_W 64

// radix-4 booth rows for a 32-bit operand plus two extension bits
`define MUL_PP_ROWS 17

// rows left after the 5-2 and 4-2 first level
`define MUL_L1_ROWS 8

`endif
